//--- sim.f
+incdir+src
+incdir+tests
src/dallanma_pkg.sv
src/karsilastirici.sv
src/dallanma_birimi.sv
src/dallanma_ongorucu.sv
src/dallanma_yazmaclari.sv
src/dallanma_ust.sv
tests/dallanma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dallanma_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/dallanma_wb_gorevleri.svh
`ifndef DALLANMA_WB_GOREVLERI_SVH
`define DALLANMA_WB_GOREVLERI_SVH

// polls ack once per falling edge and gives up after ACK_SINIR cycles.
task automatic ack_bekle();
    int n;
    for (n = 0; n < ACK_SINIR; n++) begin
        @(negedge clk);
        if (wb_ack) begin
            break;
        end
    end
    if (n == ACK_SINIR) begin
        hata_ile_bitir("Timeout: the register block never answered with wb_ack_o");
    end
endtask

task automatic wb_erisim(input logic yaz, input logic [W-1:0] adr,
        input logic [W-1:0] veri, output logic [W-1:0] okunan);
    @(posedge clk);
    wb_cyc     <= 1'b1;
    wb_stb     <= 1'b1;
    wb_we      <= yaz;
    wb_adr     <= adr;
    wb_dat_yaz <= veri;
    wb_sel     <= 4'hf;
    ack_bekle();
    okunan = wb_dat_oku;    // data is taken in the ack cycle.
    @(posedge clk);
    wb_cyc     <= 1'b0;     // request held until ack.
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
endtask

task automatic wb_yaz(input logic [W-1:0] adr, input logic [W-1:0] veri);
    logic [W-1:0] yok;
    wb_erisim(1'b1, adr, veri, yok);
endtask

task automatic oku_karsilastir(input logic [W-1:0] adr, input logic [W-1:0] deger);
    logic [W-1:0] veri;
    wb_erisim(1'b0, adr, 32'h0, veri);
    assert (veri == deger)
        else yanlis_deger($sformatf("read %h at offset %h, expected %h", veri, adr, deger));
endtask

`endif

//--- tests/dallanma_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

module dallanma_tb
    import dallanma_pkg::*;
();

    localparam int W         = `DAL_VERI_GENISLIK;
    localparam int ACK_SINIR = 16;     // cycles allowed for an ack.

    logic          clk, rst, blok_aktif, ongorusu, ongoru, gecerli, atladi, hata;
    logic          wb_cyc, wb_stb, wb_we, wb_ack, kontrol_yaz;
    dal_tur_t      tur;
    logic [3:0]    wb_sel;
    logic [W-1:0]  getir_ps, ps, br, rs1, rs2, hedef, wb_adr, wb_dat_yaz, wb_dat_oku;

    cozum_t        beklenen;           // model result one cycle behind the inputs.
    logic [W-1:0]  beklenen_ps;
    ongoru_sayac_t model_tablo [`DAL_BHT_DERINLIK];
    logic [W-1:0]  model_sayac [3];
    logic          model_etkin, model_ack;

    dallanma_ust dut (
        .clk_i                   (clk),
        .rst_i                   (rst),
        .getir_ps_i              (getir_ps),
        .ongoru_o                (ongoru),
        .blok_aktif_i            (blok_aktif),
        .dal_buy_turu_i          (tur),
        .dallanma_ongorusu_i     (ongorusu),
        .ps_i                    (ps),
        .br_i                    (br),
        .rs1_i                   (rs1),
        .rs2_i                   (rs2),
        .guncelle_gecerli_o      (gecerli),
        .guncelle_atladi_o       (atladi),
        .dallanma_hata_o         (hata),
        .guncelle_hedef_adresi_o (hedef),
        .wb_cyc_i                (wb_cyc),
        .wb_stb_i                (wb_stb),
        .wb_we_i                 (wb_we),
        .wb_adr_i                (wb_adr),
        .wb_dat_i                (wb_dat_yaz),
        .wb_sel_i                (wb_sel),
        .wb_dat_o                (wb_dat_oku),
        .wb_ack_o                (wb_ack)
    );

    always #50 clk = ~clk;

    task automatic hata_ile_bitir(input string satir);
        $display("%s", satir);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic yanlis_deger(input string mesaj);
        hata_ile_bitir($sformatf("FAILED at %0t: %s", $time, mesaj));
    endtask

    `include "dallanma_wb_gorevleri.svh"

    function automatic cozum_t sonuc_hesapla(input logic aktif, input logic [2:0] kod,
            input logic tahmin, input logic [W-1:0] pc, input logic [W-1:0] ofs,
            input logic [W-1:0] a, input logic [W-1:0] b);
        cozum_t s;
        logic   al;
        logic   gec;
        s   = '0;
        al  = 1'b0;
        gec = aktif;
        case (kod)
            `BRA_BEQ:  al = (a == b);
            `BRA_BNE:  al = (a != b);
            `BRA_BLT:  al = ($signed(a) < $signed(b));
            `BRA_BGE:  al = ($signed(a) >= $signed(b));
            `BRA_BLTU: al = (a < b);
            `BRA_BGEU: al = (a >= b);
            default:   gec = 1'b0;      // 110 and 111.
        endcase
        if (gec) begin
            s.gecerli = 1'b1;
            s.atladi  = al;
            s.hata    = al ^ tahmin;
            s.hedef   = al ? pc + ofs : pc + 32'd4;
        end
        return s;
    endfunction

    assign kontrol_yaz = wb_cyc & wb_stb & wb_we & ~model_ack
                         & (wb_adr == `DAL_ADR_KONTROL) & wb_sel[0];

    // reference model that sees the same input values as the dut at each edge.
    always @(posedge clk) begin
        if (rst) begin
            beklenen    <= '0;
            model_ack   <= 1'b0;
            model_etkin <= 1'b1;
            for (int i = 0; i < `DAL_BHT_DERINLIK; i++)
                model_tablo[i] <= 2'b01;
            for (int k = 0; k < 3; k++)
                model_sayac[k] <= '0;
        end else begin
            beklenen    <= sonuc_hesapla(blok_aktif, tur, ongorusu, ps, br, rs1, rs2);
            beklenen_ps <= ps;
            model_ack   <= wb_cyc & wb_stb & ~model_ack;
            if (kontrol_yaz)
                model_etkin <= wb_dat_yaz[0];
            if (beklenen.gecerli && beklenen.atladi && model_tablo[beklenen_ps[5:2]] != 2'b11)
                model_tablo[beklenen_ps[5:2]] <= model_tablo[beklenen_ps[5:2]] + 2'b01;
            if (beklenen.gecerli && !beklenen.atladi && model_tablo[beklenen_ps[5:2]] != 2'b00)
                model_tablo[beklenen_ps[5:2]] <= model_tablo[beklenen_ps[5:2]] - 2'b01;
            if (kontrol_yaz && wb_dat_yaz[1]) begin
                for (int k = 0; k < 3; k++)
                    model_sayac[k] <= '0;   // clear wins.
            end else if (beklenen.gecerli) begin
                model_sayac[0] <= model_sayac[0] + 32'd1;
                model_sayac[1] <= model_sayac[1] + {31'd0, beklenen.atladi};
                model_sayac[2] <= model_sayac[2] + {31'd0, beklenen.hata};
            end
        end
    end

    // outputs are compared between edges.
    always @(negedge clk) begin
        if (!rst) begin
            assert ({gecerli, atladi, hata, hedef} == beklenen)
                else yanlis_deger($sformatf("result %h, expected %h",
                                            {gecerli, atladi, hata, hedef}, beklenen));
            assert (ongoru == (model_etkin & model_tablo[getir_ps[5:2]][1]))
                else yanlis_deger($sformatf("prediction %b for pc %h", ongoru, getir_ps));
            assert (wb_ack == model_ack)
                else yanlis_deger($sformatf("wb_ack_o is %b, expected %b", wb_ack, model_ack));
        end
    end

    ack_tek_cevrim: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else hata_ile_bitir("wb_ack_o stayed high for more than one cycle");

    task automatic dal_gonder(input logic aktif, input logic [2:0] kod, input logic tahmin,
            input logic [W-1:0] pc, input logic [W-1:0] a, input logic [W-1:0] b);
        @(posedge clk);
        blok_aktif <= aktif;
        tur        <= dal_tur_t'(kod);
        ongorusu   <= tahmin;
        ps         <= pc;
        br         <= $urandom & 32'hffff_fffe;
        rs1        <= a;
        rs2        <= b;
        getir_ps   <= $urandom;
    endtask

    task automatic dal_durdur();
        @(posedge clk);
        blok_aktif <= 1'b0;
    endtask

    task automatic ongoru_dene(input logic [W-1:0] pc, input logic deger);
        @(posedge clk);
        getir_ps <= pc;
        @(negedge clk);
        assert (ongoru == deger)
            else yanlis_deger($sformatf("prediction %b for pc %h, expected %b", ongoru, pc, deger));
    endtask

    // equal, sign crossing, extreme or plain random pairs.
    task automatic islenen_sec(output logic [W-1:0] a, output logic [W-1:0] b);
        logic [W-1:0] uclar [5];
        logic [2:0]   j;
        uclar = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        a     = $urandom;
        b     = $urandom;
        j     = 3'($urandom % 5);
        case ($urandom % 5)
            0: b = a;
            1: begin
                a[W-1] = 1'b1;
                b[W-1] = 1'b0;
            end
            2: begin
                a[W-1] = 1'b0;
                b[W-1] = 1'b1;
            end
            3: begin
                a = uclar[j];
                b = uclar[3'($urandom % 5)];
            end
            default: b = b ^ 32'h1;
        endcase
    endtask

    initial begin
        logic [W-1:0] a, b, pc_a;
        void'($urandom(39913));
        clk = 1'b0;
        rst = 1'b1;
        tur = DAL_BEQ;
        wb_sel = 4'h0;
        {blok_aktif, ongorusu, wb_cyc, wb_stb, wb_we} = '0;
        {getir_ps, ps, br, rs1, rs2, wb_adr, wb_dat_yaz} = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (8) begin
            @(posedge clk);
            getir_ps <= $urandom;
        end
        oku_karsilastir(`DAL_ADR_KONTROL, 32'h1);
        oku_karsilastir(`DAL_ADR_DAL_SAYISI, 32'h0);
        oku_karsilastir(`DAL_ADR_ATLANAN_SAYISI, 32'h0);
        oku_karsilastir(`DAL_ADR_HATA_SAYISI, 32'h0);
        pc_a = $urandom & 32'hffff_fffc;
        repeat (2) dal_gonder(1'b1, `BRA_BEQ, 1'b0, pc_a, 32'h5, 32'h5);
        dal_durdur();
        ongoru_dene(pc_a, 1'b1);
        ongoru_dene(pc_a ^ 32'h4, 1'b0);            // next index.
        wb_yaz(`DAL_ADR_KONTROL, 32'h0);
        ongoru_dene(pc_a, 1'b0);
        wb_yaz(`DAL_ADR_KONTROL, 32'h1);
        ongoru_dene(pc_a, 1'b1);
        repeat (2) dal_gonder(1'b1, `BRA_BNE, 1'b1, pc_a, 32'h5, 32'h5);
        dal_durdur();
        ongoru_dene(pc_a, 1'b0);
        for (int i = 0; i < 400; i++) begin
            islenen_sec(a, b);
            dal_gonder(($urandom % 8) != 0, 3'($urandom % 8), 1'($urandom % 2), $urandom, a, b);
        end
        dal_durdur();
        repeat (2) @(posedge clk);                  // last result reaches the counters.
        oku_karsilastir(`DAL_ADR_DAL_SAYISI, model_sayac[0]);
        oku_karsilastir(`DAL_ADR_ATLANAN_SAYISI, model_sayac[1]);
        oku_karsilastir(`DAL_ADR_HATA_SAYISI, model_sayac[2]);
        oku_karsilastir(32'h10, 32'h0);
        wb_yaz(`DAL_ADR_HATA_SAYISI, $urandom);      // read only.
        oku_karsilastir(`DAL_ADR_HATA_SAYISI, model_sayac[2]);
        wb_yaz(`DAL_ADR_KONTROL, 32'h3);
        oku_karsilastir(`DAL_ADR_KONTROL, 32'h1);
        oku_karsilastir(`DAL_ADR_DAL_SAYISI, 32'h0);
        oku_karsilastir(`DAL_ADR_ATLANAN_SAYISI, 32'h0);
        oku_karsilastir(`DAL_ADR_HATA_SAYISI, 32'h0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dallanma_ust.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

module dallanma_ust
    import dallanma_pkg::*;
(
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      getir_ps_i,
    output logic                                    ongoru_o,
    input  wire logic                               blok_aktif_i,
    input  wire dal_tur_t                           dal_buy_turu_i,
    input  wire logic                               dallanma_ongorusu_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      ps_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      br_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      rs1_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      rs2_i,
    output logic                                    guncelle_gecerli_o,
    output logic                                    guncelle_atladi_o,
    output logic                                    dallanma_hata_o,
    output logic      [`DAL_VERI_GENISLIK-1:0]      guncelle_hedef_adresi_o,
    input  wire logic                               wb_cyc_i,
    input  wire logic                               wb_stb_i,
    input  wire logic                               wb_we_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      wb_adr_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      wb_dat_i,
    input  wire logic [3:0]                         wb_sel_i,
    output logic      [`DAL_VERI_GENISLIK-1:0]      wb_dat_o,
    output logic                                    wb_ack_o
);

    logic                           esit_mi;
    logic                           kucuk_isaretli;
    logic                           kucuk_isaretsiz;
    logic                           ongoru_etkin;
    cozum_t                         cozum;
    logic [`DAL_VERI_GENISLIK-1:0]  cozum_ps;   // pc of the result in cozum.

    karsilastirici u_karsilastirici (
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .esit_mi_o         (esit_mi),
        .kucuk_isaretli_o  (kucuk_isaretli),
        .kucuk_isaretsiz_o (kucuk_isaretsiz)
    );

    dallanma_birimi u_dallanma_birimi (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .blok_aktif_i        (blok_aktif_i),
        .dal_buy_turu_i      (dal_buy_turu_i),
        .dallanma_ongorusu_i (dallanma_ongorusu_i),
        .esit_mi_i           (esit_mi),
        .kucuk_isaretli_i    (kucuk_isaretli),
        .kucuk_isaretsiz_i   (kucuk_isaretsiz),
        .ps_i                (ps_i),
        .br_i                (br_i),
        .cozum_o             (cozum)
    );

    // pc follows its result by one stage for training.
    always_ff @(posedge clk_i) begin
        cozum_ps <= ps_i;
    end

    dallanma_ongorucu u_dallanma_ongorucu (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .getir_ps_i     (getir_ps_i),
        .ongoru_etkin_i (ongoru_etkin),
        .cozum_i        (cozum),
        .cozum_ps_i     (cozum_ps),
        .ongoru_o       (ongoru_o)
    );

    dallanma_yazmaclari u_dallanma_yazmaclari (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .cozum_i        (cozum),
        .ongoru_etkin_o (ongoru_etkin)
    );

    assign guncelle_gecerli_o      = cozum.gecerli;
    assign guncelle_atladi_o       = cozum.atladi;
    assign dallanma_hata_o         = cozum.hata;
    assign guncelle_hedef_adresi_o = cozum.hedef;

endmodule

`default_nettype wire

//--- src/dallanma_yazmaclari.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

module dallanma_yazmaclari
    import dallanma_pkg::*;
(
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic                               wb_cyc_i,
    input  wire logic                               wb_stb_i,
    input  wire logic                               wb_we_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      wb_adr_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      wb_dat_i,
    input  wire logic [3:0]                         wb_sel_i,
    output logic      [`DAL_VERI_GENISLIK-1:0]      wb_dat_o,
    output logic                                    wb_ack_o,
    input  wire cozum_t                             cozum_i,
    output logic                                    ongoru_etkin_o
);

    logic                           istek;
    logic                           yazma;
    logic                           kontrol_yaz;
    logic                           temizle;
    logic [2:0]                     olay;
    logic [`DAL_VERI_GENISLIK-1:0]  sayaclar [3];
    logic [`DAL_VERI_GENISLIK-1:0]  okuma_verisi;

    // new request only, so ack stays a single cycle pulse.
    assign istek = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign yazma = istek & wb_we_i;

    // control lives in byte lane 0.
    assign kontrol_yaz = yazma & (wb_adr_i == `DAL_ADR_KONTROL) & wb_sel_i[0];
    assign temizle     = kontrol_yaz & wb_dat_i[1];

    // event bit 0 is valid, bit 1 taken and bit 2 mispredict.
    assign olay[0] = cozum_i.gecerli;
    assign olay[1] = cozum_i.gecerli & cozum_i.atladi;
    assign olay[2] = cozum_i.gecerli & cozum_i.hata;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= istek;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ongoru_etkin_o <= 1'b1;     // predictor on out of reset.
        end else if (kontrol_yaz) begin
            ongoru_etkin_o <= wb_dat_i[0];
        end
    end

    // event counters where a clear beats an increment.
    always_ff @(posedge clk_i) begin
        if (rst_i || temizle) begin
            for (int k = 0; k < 3; k++) begin
                sayaclar[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (olay[k]) begin
                    sayaclar[k] <= sayaclar[k] + 1'b1;
                end
            end
        end
    end

    // read mux where bit 1 of control never reads back.
    always_comb begin
        case (wb_adr_i)
            `DAL_ADR_KONTROL: begin
                okuma_verisi = {{(`DAL_VERI_GENISLIK-1){1'b0}}, ongoru_etkin_o};
            end
            `DAL_ADR_DAL_SAYISI: begin
                okuma_verisi = sayaclar[0];
            end
            `DAL_ADR_ATLANAN_SAYISI: begin
                okuma_verisi = sayaclar[1];
            end
            `DAL_ADR_HATA_SAYISI: begin
                okuma_verisi = sayaclar[2];
            end
            default: begin
                okuma_verisi = '0;  // unmapped.
            end
        endcase
    end

    // data launched together with ack.
    always_ff @(posedge clk_i) begin
        if (istek) begin
            wb_dat_o <= okuma_verisi;
        end
    end

endmodule

`default_nettype wire

//--- src/dallanma_ongorucu.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

module dallanma_ongorucu
    import dallanma_pkg::*;
(
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      getir_ps_i,
    input  wire logic                               ongoru_etkin_i,
    input  wire cozum_t                             cozum_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      cozum_ps_i,
    output logic                                    ongoru_o
);

    ongoru_sayac_t                   tablo [`DAL_BHT_DERINLIK];

    logic [`DAL_BHT_INDIS_BIT-1:0]   getir_indis;
    logic [`DAL_BHT_INDIS_BIT-1:0]   guncel_indis;
    ongoru_sayac_t                   eski_sayac;
    ongoru_sayac_t                   yeni_sayac;

    // word aligned pc, so bits 1:0 are skipped.
    assign getir_indis  = getir_ps_i[`DAL_BHT_INDIS_BIT+1:2];
    assign guncel_indis = cozum_ps_i[`DAL_BHT_INDIS_BIT+1:2];

    // fetch side read of the counter msb.
    assign ongoru_o = ongoru_etkin_i & tablo[getir_indis][1];

    assign eski_sayac = tablo[guncel_indis];

    // saturating step toward the outcome.
    always_comb begin
        yeni_sayac = eski_sayac;
        if (cozum_i.atladi) begin
            if (eski_sayac != 2'b11) begin
                yeni_sayac = eski_sayac + 2'b01;
            end
        end else begin
            if (eski_sayac != 2'b00) begin
                yeni_sayac = eski_sayac - 2'b01;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `DAL_BHT_DERINLIK; i++) begin
                tablo[i] <= 2'b01;  // weakly not taken.
            end
        end else if (cozum_i.gecerli) begin
            tablo[guncel_indis] <= yeni_sayac;
        end
    end

endmodule

`default_nettype wire

//--- src/dallanma_birimi.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

module dallanma_birimi
    import dallanma_pkg::*;
(
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic                               blok_aktif_i,
    input  wire dal_tur_t                           dal_buy_turu_i,
    input  wire logic                               dallanma_ongorusu_i,
    input  wire logic                               esit_mi_i,
    input  wire logic                               kucuk_isaretli_i,
    input  wire logic                               kucuk_isaretsiz_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      ps_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0]      br_i,
    output cozum_t                                  cozum_o
);

    logic   gecerli_d;
    logic   atladi_d;
    cozum_t sonraki;

    // taken condition per branch kind.
    always_comb begin
        gecerli_d = blok_aktif_i;
        atladi_d  = 1'b0;
        case (dal_buy_turu_i)
            DAL_BEQ: begin
                atladi_d = esit_mi_i;
            end
            DAL_BNE: begin
                atladi_d = ~esit_mi_i;
            end
            DAL_BLT: begin
                atladi_d = kucuk_isaretli_i;
            end
            DAL_BGE: begin
                atladi_d = ~kucuk_isaretli_i;
            end
            DAL_BLTU: begin
                atladi_d = kucuk_isaretsiz_i;
            end
            DAL_BGEU: begin
                atladi_d = ~kucuk_isaretsiz_i;
            end
            default: begin
                gecerli_d = 1'b0;   // codes 110 and 111.
            end
        endcase
    end

    // result word stays all zero unless a valid branch is present.
    always_comb begin
        sonraki = '0;
        if (gecerli_d) begin
            sonraki.gecerli = 1'b1;
            sonraki.atladi  = atladi_d;
            sonraki.hata    = atladi_d ^ dallanma_ongorusu_i;
            if (atladi_d) begin
                sonraki.hedef = ps_i + br_i;
            end else begin
                // fetch restart point after a wrong taken guess.
                sonraki.hedef = ps_i + `DAL_VERI_GENISLIK'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cozum_o <= '0;
        end else begin
            cozum_o <= sonraki;     // new result every cycle.
        end
    end

endmodule

`default_nettype wire

//--- src/karsilastirici.sv
`timescale 1ns/100ps
`default_nettype none

`include "dallanma_macros.svh"

// One subtractor serves all six branch conditions. The borrow out gives
// the unsigned result; the signed result falls back to the sign bits
// when the operands differ in sign.
module karsilastirici (
    input  wire logic [`DAL_VERI_GENISLIK-1:0] rs1_i,
    input  wire logic [`DAL_VERI_GENISLIK-1:0] rs2_i,
    output logic                               esit_mi_o,
    output logic                               kucuk_isaretli_o,
    output logic                               kucuk_isaretsiz_o
);

    logic [`DAL_VERI_GENISLIK:0]   fark;      // one extra bit for the borrow.
    logic                          isaret_1;
    logic                          isaret_2;

    assign fark     = {1'b0, rs1_i} - {1'b0, rs2_i};
    assign isaret_1 = rs1_i[`DAL_VERI_GENISLIK-1];
    assign isaret_2 = rs2_i[`DAL_VERI_GENISLIK-1];

    assign esit_mi_o = (rs1_i == rs2_i);

    // borrow set means rs1 < rs2 as unsigned.
    assign kucuk_isaretsiz_o = fark[`DAL_VERI_GENISLIK];

    always_comb begin
        if (isaret_1 != isaret_2) begin
            kucuk_isaretli_o = isaret_1;    // negative one is smaller.
        end else begin
            kucuk_isaretli_o = fark[`DAL_VERI_GENISLIK-1];  // same sign cannot overflow.
        end
    end

endmodule

`default_nettype wire

//--- src/dallanma_pkg.sv
`default_nettype none

`include "dallanma_macros.svh"

package dallanma_pkg;

    // the six conditional branch kinds.
    typedef enum logic [2:0] {
        DAL_BEQ  = `BRA_BEQ,
        DAL_BNE  = `BRA_BNE,
        DAL_BLT  = `BRA_BLT,
        DAL_BGE  = `BRA_BGE,
        DAL_BLTU = `BRA_BLTU,
        DAL_BGEU = `BRA_BGEU
    } dal_tur_t;

    // 2-bit saturating counter whose msb is the prediction.
    typedef logic [1:0] ongoru_sayac_t;

    // registered resolution result of 35 bits.
    typedef struct packed {
        logic                          gecerli;  // a real branch was resolved.
        logic                          atladi;   // branch taken.
        logic                          hata;     // prediction was wrong.
        logic [`DAL_VERI_GENISLIK-1:0] hedef;    // corrected fetch address.
    } cozum_t;

endpackage

`default_nettype wire

//--- src/dallanma_macros.svh
`ifndef DALLANMA_MACROS_SVH
`define DALLANMA_MACROS_SVH

// branch type codes as sent by decode.
`define BRA_BEQ   3'b000
`define BRA_BNE   3'b001
`define BRA_BLT   3'b010
`define BRA_BGE   3'b011
`define BRA_BLTU  3'b100
`define BRA_BGEU  3'b101
// 3'b110 and 3'b111 are not valid branch kinds.

// width of pc, offset and operands.
`define DAL_VERI_GENISLIK  32

// branch history table size.
`define DAL_BHT_DERINLIK   16
`define DAL_BHT_INDIS_BIT  4     // table index taken from pc[5:2].

// register byte offsets on the wishbone port.
`define DAL_ADR_KONTROL         32'h0000_0000
`define DAL_ADR_DAL_SAYISI      32'h0000_0004
`define DAL_ADR_ATLANAN_SAYISI  32'h0000_0008
`define DAL_ADR_HATA_SAYISI     32'h0000_000C

`endif
